// ==== logic/rvCore_settings.svh ====
`ifndef RVCORE_SETTINGS_SVH
`define RVCORE_SETTINGS_SVH

// ##############################
// core-wide parameters
// ##############################

`define XLEN     32             // data and address width
`define NUM_REGS 32             // architectural registers
`define RESET_PC 32'h0000_0000  // first fetch address

`endif

// ==== logic/rvCorePkg.sv ====
`include "rvCore_settings.svh"
`default_nettype none

package rvCorePkg;

  // ##############################
  // instruction formats
  // ##############################

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rFmt;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iFmt;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } sFmt;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } bFmt;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uFmt;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jFmt;

  typedef union packed {
    rFmt rType;
    iFmt iType;
    sFmt sType;
    bFmt bType;
    uFmt uType;
    jFmt jType;
  } instWord;

  // ##############################
  // control and stage results
  // ##############################

  typedef enum logic [3:0] {ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, PASSB} aluOp;

  localparam logic [1:0] wbAlu  = 2'd0;
  localparam logic [1:0] wbMem  = 2'd1;
  localparam logic [1:0] wbLink = 2'd2;

  typedef struct packed {
    aluOp       aluOp;
    logic       aSelPc;    // operand a is pc
    logic       bSelImm;   // operand b is imm
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic [1:0] wbSel;
    logic       branch;
    logic       branchNe;
    logic       jump;
    logic       ebreak;
  } ctrl;

  typedef struct packed {
    logic [`XLEN-1:0] aluOut;
    logic [`XLEN-1:0] storeData;
    logic             takeBranch;
  } exResult;

  typedef struct packed {
    logic [`XLEN-1:0] paddr;
    logic [`XLEN-1:0] pwdata;
    logic             pwrite;
    logic             psel;
    logic             penable;
  } apbReq;

  typedef struct packed {
    logic [`XLEN-1:0] prdata;
    logic             pready;
  } apbRsp;

  typedef struct packed {
    logic             wen;
    logic [4:0]       rd;
    logic [`XLEN-1:0] data;
  } wbReq;

endpackage

`default_nettype wire

// ==== logic/fetchStage.sv ====
`include "rvCore_settings.svh"
`default_nettype none

module fetchStage (
  input  logic             clk,
  input  logic             rstN,
  input  logic             stall,
  input  rvCorePkg::ctrl   ctl,
  input  logic             takeBranch,
  input  logic [`XLEN-1:0] target,
  output logic [`XLEN-1:0] pc,
  output logic [`XLEN-1:0] linkPc,
  output logic             halt
);

  logic [`XLEN-1:0] nextPc;
  logic             redirect;

  assign linkPc   = pc + `XLEN'(4);
  assign redirect = ctl.jump || (ctl.branch && takeBranch);
  assign nextPc   = redirect ? {target[`XLEN-1:1], 1'b0} : linkPc;  // jalr clears bit 0

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc   <= `RESET_PC;
      halt <= 1'b0;
    end else begin
      if (!stall && !halt && !ctl.ebreak) begin
        pc <= nextPc;
      end
      if (ctl.ebreak) begin
        halt <= 1'b1;  // sticky until reset
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/decodeStage.sv ====
`include "rvCore_settings.svh"
`default_nettype none

module decodeStage (
  input  rvCorePkg::instWord inst,
  output rvCorePkg::ctrl     ctl,
  output logic [`XLEN-1:0]   imm,
  output logic [4:0]         rs1,
  output logic [4:0]         rs2,
  output logic [4:0]         rd
);

  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opSystem = 7'b1110011;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  rvCorePkg::aluOp arithOp;

  assign opcode = inst.rType.opcode;
  assign funct3 = inst.rType.funct3;
  assign rs1    = inst.rType.rs1;
  assign rs2    = inst.rType.rs2;
  assign rd     = inst.rType.rd;

  // shared by register and immediate arithmetic
  always_comb begin
    case (funct3)
      3'b000:  arithOp = (opcode == opReg && inst.rType.funct7[5]) ? rvCorePkg::SUB
                                                                   : rvCorePkg::ADD;
      3'b001:  arithOp = rvCorePkg::SLL;
      3'b010:  arithOp = rvCorePkg::SLT;
      3'b100:  arithOp = rvCorePkg::XOR;
      3'b101:  arithOp = rvCorePkg::SRL;
      3'b110:  arithOp = rvCorePkg::OR;
      3'b111:  arithOp = rvCorePkg::AND;
      default: arithOp = rvCorePkg::ADD;
    endcase
  end

  // ##############################
  // control
  // ##############################

  always_comb begin
    ctl = '0;  // no-op
    case (opcode)
      opReg: begin
        ctl.aluOp    = arithOp;
        ctl.regWrite = 1'b1;
      end
      opImm: begin
        ctl.aluOp    = arithOp;
        ctl.bSelImm  = 1'b1;
        ctl.regWrite = 1'b1;
      end
      opLoad: begin
        if (funct3 == 3'b010) begin  // lw only
          ctl.bSelImm  = 1'b1;
          ctl.regWrite = 1'b1;
          ctl.memRead  = 1'b1;
          ctl.wbSel    = rvCorePkg::wbMem;
        end
      end
      opStore: begin
        if (funct3 == 3'b010) begin
          ctl.bSelImm  = 1'b1;
          ctl.memWrite = 1'b1;
        end
      end
      opBranch: begin
        if (funct3[2:1] == 2'b00) begin  // beq, bne
          ctl.aSelPc   = 1'b1;
          ctl.bSelImm  = 1'b1;
          ctl.branch   = 1'b1;
          ctl.branchNe = funct3[0];
        end
      end
      opLui: begin
        ctl.aluOp    = rvCorePkg::PASSB;
        ctl.bSelImm  = 1'b1;
        ctl.regWrite = 1'b1;
      end
      opAuipc: begin
        ctl.aSelPc   = 1'b1;
        ctl.bSelImm  = 1'b1;
        ctl.regWrite = 1'b1;
      end
      opJal: begin
        ctl.aSelPc   = 1'b1;
        ctl.bSelImm  = 1'b1;
        ctl.regWrite = 1'b1;
        ctl.jump     = 1'b1;
        ctl.wbSel    = rvCorePkg::wbLink;
      end
      opJalr: begin
        ctl.bSelImm  = 1'b1;
        ctl.regWrite = 1'b1;
        ctl.jump     = 1'b1;
        ctl.wbSel    = rvCorePkg::wbLink;
      end
      opSystem: begin
        ctl.ebreak = (inst.iType.imm11_0 == 12'd1) && (funct3 == 3'b000);
      end
      default: ;
    endcase
  end

  // ##############################
  // immediates
  // ##############################

  always_comb begin
    case (opcode)
      opStore:      imm = {{20{inst.sType.imm11_5[6]}}, inst.sType.imm11_5,
                           inst.sType.imm4_0};
      opBranch:     imm = {{19{inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
                           inst.bType.imm10_5, inst.bType.imm4_1, 1'b0};
      opLui,
      opAuipc:      imm = {inst.uType.imm31_12, 12'b0};
      opJal:        imm = {{11{inst.jType.imm20}}, inst.jType.imm20, inst.jType.imm19_12,
                           inst.jType.imm11, inst.jType.imm10_1, 1'b0};
      default:      imm = {{20{inst.iType.imm11_0[11]}}, inst.iType.imm11_0};
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`include "rvCore_settings.svh"
`default_nettype none

module regFile (
  input  logic             clk,
  input  logic             rstN,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  input  rvCorePkg::wbReq  wb,
  output logic [`XLEN-1:0] rdata1,
  output logic [`XLEN-1:0] rdata2
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wen && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];  // x0 hardwired
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
`include "rvCore_settings.svh"
`default_nettype none

module executeStage (
  input  rvCorePkg::ctrl     ctl,
  input  logic [`XLEN-1:0]   pc,
  input  logic [`XLEN-1:0]   imm,
  input  logic [`XLEN-1:0]   rdata1,
  input  logic [`XLEN-1:0]   rdata2,
  output rvCorePkg::exResult ex
);

  logic [`XLEN-1:0] opA;
  logic [`XLEN-1:0] opB;
  logic [`XLEN-1:0] aluOut;
  logic             lessThan;
  logic             takeBranch;

  assign opA      = ctl.aSelPc ? pc : rdata1;
  assign opB      = ctl.bSelImm ? imm : rdata2;
  assign lessThan = $signed(opA) < $signed(opB);

  always_comb begin
    case (ctl.aluOp)
      rvCorePkg::SUB:   aluOut = opA - opB;
      rvCorePkg::AND:   aluOut = opA & opB;
      rvCorePkg::OR:    aluOut = opA | opB;
      rvCorePkg::XOR:   aluOut = opA ^ opB;
      rvCorePkg::SLT:   aluOut = {{(`XLEN-1){1'b0}}, lessThan};
      rvCorePkg::SLL:   aluOut = opA << opB[4:0];
      rvCorePkg::SRL:   aluOut = opA >> opB[4:0];
      rvCorePkg::PASSB: aluOut = opB;  // lui
      default:          aluOut = opA + opB;
    endcase
  end

  // compare works on register data, alu computes the target
  assign takeBranch = ctl.branchNe ? (rdata1 != rdata2) : (rdata1 == rdata2);

  assign ex = '{aluOut: aluOut, storeData: rdata2, takeBranch: takeBranch};

endmodule

`default_nettype wire

// ==== logic/memWbStage.sv ====
`include "rvCore_settings.svh"
`default_nettype none

module memWbStage (
  input  logic               clk,
  input  logic               rstN,
  input  rvCorePkg::ctrl     ctl,
  input  rvCorePkg::exResult ex,
  input  logic [4:0]         rd,
  input  logic [`XLEN-1:0]   linkPc,
  input  logic               halt,
  output rvCorePkg::apbReq   apbOut,
  input  rvCorePkg::apbRsp   apbIn,
  output logic               stall,
  output rvCorePkg::wbReq    wb
);

  typedef enum logic [1:0] {sIdle, sSetup, sAccess} apbState;

  apbState          state;
  apbState          phase;
  apbState          nextState;
  logic             start;
  logic             done;
  logic [`XLEN-1:0] wbData;

  // ##############################
  // apb master
  // ##############################

  assign start = (ctl.memRead || ctl.memWrite) && !halt;

  // setup is issued in the instruction's first cycle
  always_comb begin
    phase = state;
    if (state == sIdle && start) begin
      phase = sSetup;
    end
  end

  always_comb begin
    case (phase)
      sSetup:  nextState = sAccess;
      sAccess: nextState = apbIn.pready ? sIdle : sAccess;
      default: nextState = sIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= sIdle;
    end else begin
      state <= nextState;
    end
  end

  assign done  = (phase == sAccess) && apbIn.pready;
  assign stall = (phase != sIdle) && !done;

  assign apbOut.paddr   = ex.aluOut;
  assign apbOut.pwdata  = ex.storeData;
  assign apbOut.pwrite  = ctl.memWrite && (phase != sIdle);
  assign apbOut.psel    = (phase != sIdle);
  assign apbOut.penable = (phase == sAccess);

  // ##############################
  // writeback
  // ##############################

  always_comb begin
    case (ctl.wbSel)
      rvCorePkg::wbMem:  wbData = apbIn.prdata;  // sampled on the completing edge
      rvCorePkg::wbLink: wbData = linkPc;
      default:           wbData = ex.aluOut;
    endcase
  end

  assign wb.wen  = ctl.regWrite && !stall && !halt;
  assign wb.rd   = rd;
  assign wb.data = wbData;

endmodule

`default_nettype wire

// ==== logic/rvCore.sv ====
`include "rvCore_settings.svh"
`default_nettype none

module rvCore (
  input  logic               clk,
  input  logic               rstN,
  input  rvCorePkg::instWord inst,
  output logic [`XLEN-1:0]   pc,
  output rvCorePkg::apbReq   apbOut,
  input  rvCorePkg::apbRsp   apbIn,
  output logic               halt
);

  rvCorePkg::ctrl     ctl;
  rvCorePkg::exResult ex;
  rvCorePkg::wbReq    wb;
  logic [`XLEN-1:0]   imm;
  logic [`XLEN-1:0]   rdata1;
  logic [`XLEN-1:0]   rdata2;
  logic [`XLEN-1:0]   linkPc;
  logic [4:0]         rs1;
  logic [4:0]         rs2;
  logic [4:0]         rd;
  logic               stall;

  fetchStage fetch0 (
    .clk(clk), .rstN(rstN), .stall(stall), .ctl(ctl), .takeBranch(ex.takeBranch),
    .target(ex.aluOut), .pc(pc), .linkPc(linkPc), .halt(halt)
  );

  decodeStage decode0 (
    .inst(inst), .ctl(ctl), .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd)
  );

  regFile regs0 (
    .clk(clk), .rstN(rstN), .rs1(rs1), .rs2(rs2), .wb(wb),
    .rdata1(rdata1), .rdata2(rdata2)
  );

  executeStage execute0 (
    .ctl(ctl), .pc(pc), .imm(imm), .rdata1(rdata1), .rdata2(rdata2), .ex(ex)
  );

  memWbStage memWb0 (
    .clk(clk), .rstN(rstN), .ctl(ctl), .ex(ex), .rd(rd), .linkPc(linkPc),
    .halt(halt), .apbOut(apbOut), .apbIn(apbIn), .stall(stall), .wb(wb)
  );

endmodule

`default_nettype wire

// ==== testbench/rvCore_sva.sv ====
`include "rvCore_settings.svh"
`default_nettype none

module rvCore_sva (
  input logic             clk,
  input logic             rstN,
  input logic [`XLEN-1:0] pc,
  input rvCorePkg::apbReq apbOut,
  input rvCorePkg::apbRsp apbIn,
  input logic             halt
);

  timeunit 1ns;
  timeprecision 1ps;

  // ##############################
  // apb protocol
  // ##############################

  idleAfterReset: assert property (@(posedge clk)
    !rstN |=> !apbOut.psel && !apbOut.penable && !apbOut.pwrite && !halt)
    else $error("bus or halt active after reset");

  accessAfterSetup: assert property (@(posedge clk) disable iff (!rstN)
    apbOut.penable |-> $past(apbOut.psel)
      && (!$past(apbOut.penable) || !$past(apbIn.pready)))
    else $error("access phase not preceded by a setup phase");

  setupThenAccess: assert property (@(posedge clk) disable iff (!rstN)
    apbOut.psel && !apbOut.penable |=> apbOut.psel && apbOut.penable
      && $stable(apbOut.paddr) && $stable(apbOut.pwrite) && $stable(apbOut.pwdata))
    else $error("setup phase not followed by a stable access phase");

  holdWhileWaiting: assert property (@(posedge clk) disable iff (!rstN)
    apbOut.penable && !apbIn.pready |=> apbOut.psel && apbOut.penable
      && $stable(apbOut.paddr) && $stable(apbOut.pwrite) && $stable(apbOut.pwdata))
    else $error("access phase changed while pready low");

  // ##############################
  // halt
  // ##############################

  haltSticky: assert property (@(posedge clk) disable iff (!rstN)
    halt |=> halt && $stable(pc))
    else $error("halt dropped or pc moved after halt");

  noBusAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
    halt |-> !apbOut.psel)
    else $error("apb transfer started after halt");

endmodule

bind rvCore rvCore_sva sva0 (
  .clk(clk), .rstN(rstN), .pc(pc), .apbOut(apbOut), .apbIn(apbIn), .halt(halt)
);

`default_nettype wire

// ==== testbench/rvCore_tb.sv ====
`include "rvCore_settings.svh"
`default_nettype none

module rvCore_tb;

  timeunit 1ns;
  timeprecision 1ps;

  logic               clk;
  logic               rstN;
  logic [`XLEN-1:0]   pc;
  logic               halt;
  rvCorePkg::instWord inst;
  rvCorePkg::apbReq   apbOut;
  rvCorePkg::apbRsp   apbIn;

  logic [31:0]        stim [64];
  rvCorePkg::instWord prog [64];
  rvCorePkg::apbReq   expStore [16];
  logic [`XLEN-1:0]   haltPc;
  logic [`XLEN-1:0]   mem [256];
  int                 progLen;
  int                 storeCount;
  int                 storeIdx;
  int                 cycles;
  int                 limit;
  int                 waits;
  logic [31:0]        lfsrState;
  logic               readyBit;

  rvCore dut0 (
    .clk(clk), .rstN(rstN), .inst(inst), .pc(pc), .apbOut(apbOut), .apbIn(apbIn),
    .halt(halt)
  );

  always #5 clk = ~clk;

  assign inst = prog[pc[7:2]];  // instruction rom

  function automatic logic [31:0] stepLfsr(input logic [31:0] s);
    logic [31:0] stepped;
    stepped = s >> 1;
    if (s[0]) begin
      stepped = stepped ^ 32'h8020_0003;
    end
    return stepped;
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // ##############################
  // checks
  // ##############################

  task automatic checkStore(input rvCorePkg::apbReq got, input rvCorePkg::apbReq exp);
    if (got.paddr !== exp.paddr) begin
      failRun($sformatf("Error at %0t: paddr expected %h actual %h",
                        $time, exp.paddr, got.paddr));
    end
    if (got.pwdata !== exp.pwdata) begin
      failRun($sformatf("Error at %0t: pwdata expected %h actual %h",
                        $time, exp.pwdata, got.pwdata));
    end
  endtask

  task automatic checkPc(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      failRun($sformatf("Error at %0t: pc expected %h actual %h", $time, exp, got));
    end
  endtask

  // ##############################
  // apb slave memory
  // ##############################

  always @(posedge clk) begin
    if (rstN && apbOut.psel && apbOut.penable && apbIn.pready && apbOut.pwrite) begin
      mem[apbOut.paddr[9:2]] = apbOut.pwdata;
      if (storeIdx >= storeCount) begin
        failRun("more stores were made than the program expects");
      end
      checkStore(apbOut, expStore[storeIdx]);
      storeIdx++;
    end
    #1;
    if (apbOut.psel && apbOut.penable) begin
      if (waits >= 3) begin
        readyBit = 1'b1;  // cap at 3 wait states
      end else begin
        readyBit  = lfsrState[0];
        lfsrState = stepLfsr(lfsrState);
      end
      waits = readyBit ? 0 : waits + 1;
      apbIn.pready = readyBit;
    end else begin
      apbIn.pready = 1'b0;
      waits        = 0;
    end
    apbIn.prdata = mem[apbOut.paddr[9:2]];
  end

  always @(posedge clk) begin
    if (rstN) begin
      cycles++;
      if (cycles >= limit) begin
        failRun("timeout: the core did not halt within the cycle limit");
      end
    end
  end

  // ##############################
  // main sequence
  // ##############################

  initial begin
    clk        = 1'b0;
    rstN       = 1'b0;
    apbIn      = '0;
    cycles     = 0;
    storeIdx   = 0;
    waits      = 0;
    readyBit   = 1'b0;
    lfsrState  = 32'h1746_c1a3;
    $readmemh("testbench/rvCore_stim.txt", stim);
    progLen    = int'(stim[0]);
    storeCount = int'(stim[1]);
    limit      = progLen * 8 + 100;
    for (int i = 0; i < 64; i++) begin
      prog[i] = (i < progLen) ? stim[2 + i] : 32'h0;
    end
    for (int i = 0; i < storeCount; i++) begin
      expStore[i]        = '0;
      expStore[i].paddr  = stim[2 + progLen + 2 * i];
      expStore[i].pwdata = stim[3 + progLen + 2 * i];
    end
    haltPc = stim[2 + progLen + 2 * storeCount];
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0203);  // address-dependent fill
    end
    repeat (8) @(posedge clk);
    #1 rstN = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!halt);
    checkPc(pc, haltPc);
    repeat (4) @(posedge clk);
    #2;
    checkPc(pc, haltPc);
    if (storeIdx != storeCount) begin
      failRun($sformatf("only %0d of %0d expected stores were seen", storeIdx, storeCount));
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/rvCore_stim.txt ====
// word 0 program length, word 1 store record count
// then program words, then store records (address, data), then halt pc
1F 09
00500093 FFD00113 002081B3 00302023  // arithmetic, first store
40110233 00402223 001122B3 00502423  // sub, slt with negative operand
00409313 001153B3 00734433 00802623  // shifts and xor
123454B7 6784E493 00902823 01002503  // lui, ori, store then load back
00150513 00A02A23 00208463 00209463  // loaded value reused, beq, bne
00102C23 008005EF 00102E23 00B02C23  // skipped store, jal link
00000617 00C606E7 00102E23 00C6F733  // auipc, jalr
00D02E23 02E02023 00100073           // link stores, ebreak
00000000 00000002
00000004 FFFFFFF8
00000008 00000001
0000000C 07FFFFAF
00000010 12345678
00000014 12345679
00000018 00000058
0000001C 00000068
00000020 00000060
00000078

// ==== tb.f ====
+incdir+logic
logic/rvCorePkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/regFile.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/rvCore.sv
testbench/rvCore_sva.sv
testbench/rvCore_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the rvCore testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module rvCore_tb -o simRvCore
./obj_dir/simRvCore
